// ==== verilog/core_pkg.sv ====
`default_nettype none

package core_pkg;

	// ------------------------------
	// Widths and sizes
	// ------------------------------
	localparam int XLEN       = 32;
	localparam int NUM_REGS   = 32;
	localparam int NUM_SLOTS  = 3;                                   // Works for 2 to 6
	localparam int SLOT_IDX_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

	typedef logic [XLEN-1:0]       xlen_t;
	typedef logic [4:0]            reg_idx_t;
	typedef logic [SLOT_IDX_W-1:0] slot_idx_t;

	// ------------------------------
	// Opcodes
	// ------------------------------
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

	localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
	localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;               // SUB and SRA
	localparam logic [6:0] FUNCT7_MUL  = 7'b0000001;

	// Top bit is funct7[5], low bits are funct3
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111,
		ALU_SUB  = 4'b1000,
		ALU_SRA  = 4'b1101
	} alu_op_e;

	typedef enum logic [1:0] {
		FWD_REGFILE = 2'd0,
		FWD_ISSUE   = 2'd1,                                          // ALU result in issue register
		FWD_SLOT    = 2'd2
	} fwd_sel_e;

	// ------------------------------
	// Bundles
	// ------------------------------
	typedef struct packed {
		xlen_t       pc;
		logic [31:0] inst;
	} fetch_t;

	typedef struct packed {
		reg_idx_t rd;
		logic     we;                                                // Write to nonzero rd
		logic     is_mul;
		alu_op_e  alu_op;
		xlen_t    opa;
		xlen_t    opb;
	} issue_t;

	typedef struct packed {
		logic     valid;
		logic     we;
		reg_idx_t rd;
		logic     ready;                                             // Data is final
		xlen_t    data;
	} slot_t;

	typedef struct packed {
		reg_idx_t rd;
		xlen_t    data;
	} retire_t;

endpackage

`default_nettype wire

// ==== verilog/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	input  wire core_pkg::fetch_t    fetch,
	input  wire                      fetch_valid,
	input  wire core_pkg::xlen_t     rs1_data,
	input  wire core_pkg::xlen_t     rs2_data,
	input  wire core_pkg::fwd_sel_e  sel1,
	input  wire core_pkg::fwd_sel_e  sel2,
	input  wire core_pkg::slot_idx_t slot_idx1,
	input  wire core_pkg::slot_idx_t slot_idx2,
	input  wire core_pkg::xlen_t     alu_result,
	input  wire core_pkg::xlen_t     slot_data [core_pkg::NUM_SLOTS],
	input  wire                      stall,
	output core_pkg::reg_idx_t       rs1,
	output core_pkg::reg_idx_t       rs2,
	output logic                     use1,
	output logic                     use2,
	output core_pkg::issue_t         issue,
	output logic                     issue_valid,
	output logic                     fetch_ready
);

	logic [6:0]         opcode;
	logic [2:0]         funct3;
	logic [6:0]         funct7;
	core_pkg::reg_idx_t rd;
	core_pkg::xlen_t    imm_i;
	core_pkg::xlen_t    imm_u;
	core_pkg::xlen_t    src1;
	core_pkg::xlen_t    src2;
	logic               legal;
	logic               reads_rs1;
	logic               reads_rs2;

	// ------------------------------
	// Field split
	// ------------------------------
	assign opcode = fetch.inst[6:0];
	assign rd     = fetch.inst[11:7];
	assign funct3 = fetch.inst[14:12];
	assign rs1    = fetch.inst[19:15];
	assign rs2    = fetch.inst[24:20];
	assign funct7 = fetch.inst[31:25];

	assign imm_i = {{20{fetch.inst[31]}}, fetch.inst[31:20]};
	assign imm_u = {fetch.inst[31:12], 12'b0};

	// Youngest in-flight value wins over the register file
	assign src1 = (sel1 == core_pkg::FWD_ISSUE) ? alu_result :
		(sel1 == core_pkg::FWD_SLOT) ? slot_data[slot_idx1] : rs1_data;
	assign src2 = (sel2 == core_pkg::FWD_ISSUE) ? alu_result :
		(sel2 == core_pkg::FWD_SLOT) ? slot_data[slot_idx2] : rs2_data;

	// ------------------------------
	// Decode
	// ------------------------------
	always_comb begin
		legal        = 1'b0;
		reads_rs1    = 1'b0;
		reads_rs2    = 1'b0;
		issue.rd     = rd;
		issue.is_mul = 1'b0;
		issue.alu_op = core_pkg::ALU_ADD;
		issue.opa    = src1;
		issue.opb    = imm_i;                                        // Immediate unless OP
		case (opcode)
			core_pkg::OPC_OP: begin
				reads_rs1 = 1'b1;
				reads_rs2 = 1'b1;
				issue.opb = src2;
				if (funct7 == core_pkg::FUNCT7_MUL) begin
					legal        = (funct3 == 3'b000);           // MUL only, no MULH*
					issue.is_mul = legal;
				end else if (funct7 == core_pkg::FUNCT7_BASE) begin
					legal = 1'b1;
				end else if (funct7 == core_pkg::FUNCT7_ALT) begin
					legal = (funct3 == 3'b000) || (funct3 == 3'b101);
				end
				if (legal && !issue.is_mul)
					issue.alu_op = core_pkg::alu_op_e'({funct7[5], funct3});
			end
			core_pkg::OPC_OP_IMM: begin
				reads_rs1 = 1'b1;
				case (funct3)
					3'b001: legal = (funct7 == core_pkg::FUNCT7_BASE);
					3'b101: legal = (funct7 == core_pkg::FUNCT7_BASE) ||
						(funct7 == core_pkg::FUNCT7_ALT);
					default: legal = 1'b1;
				endcase
				if (legal)                                               // funct7[5] only for shifts right
					issue.alu_op = core_pkg::alu_op_e'(
						{(funct3 == 3'b101) && funct7[5], funct3});
			end
			core_pkg::OPC_LUI: begin
				legal     = 1'b1;
				issue.opa = '0;
				issue.opb = imm_u;
			end
			core_pkg::OPC_AUIPC: begin
				legal     = 1'b1;
				issue.opa = fetch.pc;
				issue.opb = imm_u;
			end
			default: begin
				legal = 1'b0;                                    // Bubble
			end
		endcase
		issue.we = legal && (rd != 5'd0);
	end

	// Only a live, legal instruction asks the hazard check
	assign use1 = fetch_valid && legal && reads_rs1;
	assign use2 = fetch_valid && legal && reads_rs2;

	assign fetch_ready = !stall;
	assign issue_valid = fetch_valid && legal && !stall;

endmodule

`default_nettype wire

// ==== verilog/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
	input  wire core_pkg::reg_idx_t  rs1,
	input  wire core_pkg::reg_idx_t  rs2,
	input  wire                      use1,
	input  wire                      use2,
	input  wire core_pkg::issue_t    issue,
	input  wire                      issue_live,
	input  wire core_pkg::slot_t     slots [core_pkg::NUM_SLOTS],
	output core_pkg::fwd_sel_e       sel1,
	output core_pkg::fwd_sel_e       sel2,
	output core_pkg::slot_idx_t      slot_idx1,
	output core_pkg::slot_idx_t      slot_idx2,
	output logic                     stall
);

	logic wait1;
	logic wait2;

	// Oldest slot first so the youngest match overwrites, issue register last
	function automatic void match_src(
		input  core_pkg::reg_idx_t  rs,
		input  logic                use_rs,
		output core_pkg::fwd_sel_e  sel,
		output core_pkg::slot_idx_t idx,
		output logic                not_ready
	);
		int i;
		sel       = core_pkg::FWD_REGFILE;
		idx       = '0;
		not_ready = 1'b0;
		if (use_rs && (rs != 5'd0)) begin                            // x0 never matches
			for (i = core_pkg::NUM_SLOTS - 1; i >= 0; i--) begin
				if (slots[i].valid && slots[i].we && (slots[i].rd == rs)) begin
					sel       = core_pkg::FWD_SLOT;
					idx       = core_pkg::slot_idx_t'(i);
					not_ready = !slots[i].ready;
				end
			end
			if (issue_live && issue.we && (issue.rd == rs)) begin
				sel       = core_pkg::FWD_ISSUE;
				not_ready = issue.is_mul;                        // Product not out yet
			end
		end
	endfunction

	always_comb begin
		match_src(rs1, use1, sel1, slot_idx1, wait1);
		match_src(rs2, use2, sel2, slot_idx2, wait2);
	end

	assign stall = wait1 || wait2;

endmodule

`default_nettype wire

// ==== verilog/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire core_pkg::issue_t issue,
	input  wire                   issue_valid,
	output core_pkg::issue_t      issue_q,
	output logic                  issue_live,
	output core_pkg::xlen_t       alu_result,
	output core_pkg::slot_t       slot_in,
	output logic                  mul_done,
	output core_pkg::xlen_t       mul_data
);

	core_pkg::xlen_t product;
	logic            mul_live;

	// ------------------------------
	// Issue register
	// ------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			issue_live <= 1'b0;
			mul_done   <= 1'b0;
		end else begin
			issue_live <= issue_valid;
			mul_done   <= mul_live;                                  // Product lands with MUL in slot 0
		end
	end

	always_ff @(posedge clk) begin
		if (issue_valid)
			issue_q <= issue;
		if (mul_live)
			mul_data <= product;
	end

	assign mul_live = issue_live && issue_q.is_mul;

	// ------------------------------
	// ALU and multiplier
	// ------------------------------
	always_comb begin
		case (issue_q.alu_op)
			core_pkg::ALU_SUB:  alu_result = issue_q.opa - issue_q.opb;
			core_pkg::ALU_SLL:  alu_result = issue_q.opa << issue_q.opb[4:0];
			core_pkg::ALU_SLT:  alu_result = {31'b0, $signed(issue_q.opa) < $signed(issue_q.opb)};
			core_pkg::ALU_SLTU: alu_result = {31'b0, issue_q.opa < issue_q.opb};
			core_pkg::ALU_XOR:  alu_result = issue_q.opa ^ issue_q.opb;
			core_pkg::ALU_SRL:  alu_result = issue_q.opa >> issue_q.opb[4:0];
			core_pkg::ALU_SRA:  alu_result = $signed(issue_q.opa) >>> issue_q.opb[4:0];
			core_pkg::ALU_OR:   alu_result = issue_q.opa | issue_q.opb;
			core_pkg::ALU_AND:  alu_result = issue_q.opa & issue_q.opb;
			default:            alu_result = issue_q.opa + issue_q.opb;
		endcase
	end

	assign product = issue_q.opa * issue_q.opb;                      // Low 32 bits only

	// MUL enters slot 0 pending, data is filled by broadcast
	assign slot_in.valid = issue_live;
	assign slot_in.we    = issue_q.we;
	assign slot_in.rd    = issue_q.rd;
	assign slot_in.ready = !issue_q.is_mul;
	assign slot_in.data  = alu_result;

endmodule

`default_nettype wire

// ==== verilog/retire_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

module retire_slot (
	input  wire                  clk,
	input  wire                  arst_n,
	input  wire core_pkg::slot_t entry_in,
	input  wire                  mul_done,
	input  wire core_pkg::xlen_t mul_data,
	output core_pkg::slot_t      entry
);

	core_pkg::slot_t entry_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			entry_q.valid <= 1'b0;
		else
			entry_q <= entry_in;
	end

	// Pending MUL picks up the broadcast product
	always_comb begin
		entry = entry_q;
		if (entry_q.valid && !entry_q.ready && mul_done) begin
			entry.ready = 1'b1;
			entry.data  = mul_data;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire core_pkg::reg_idx_t ra1,
	input  wire core_pkg::reg_idx_t ra2,
	input  wire core_pkg::slot_t    wr,
	output core_pkg::xlen_t         rd1,
	output core_pkg::xlen_t         rd2
);

	core_pkg::xlen_t regs [core_pkg::NUM_REGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < core_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr.valid && wr.we && (wr.rd != 5'd0)) begin
			regs[wr.rd] <= wr.data;                                  // x0 stays zero
		end
	end

	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

endmodule

`default_nettype wire

// ==== verilog/issue_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_core_top (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire core_pkg::fetch_t fetch,
	input  wire                   fetch_valid,
	output logic                  fetch_ready,
	output logic                  retire_valid,
	output core_pkg::retire_t     retire
);

	core_pkg::reg_idx_t  rs1;
	core_pkg::reg_idx_t  rs2;
	logic                use1;
	logic                use2;
	core_pkg::xlen_t     rs1_data;
	core_pkg::xlen_t     rs2_data;
	core_pkg::fwd_sel_e  sel1;
	core_pkg::fwd_sel_e  sel2;
	core_pkg::slot_idx_t slot_idx1;
	core_pkg::slot_idx_t slot_idx2;
	logic                stall;
	core_pkg::issue_t    issue;
	logic                issue_valid;
	core_pkg::issue_t    issue_q;
	logic                issue_live;
	core_pkg::xlen_t     alu_result;
	core_pkg::slot_t     slot_in;
	logic                mul_done;
	core_pkg::xlen_t     mul_data;
	core_pkg::slot_t     slots     [core_pkg::NUM_SLOTS];
	core_pkg::xlen_t     slot_data [core_pkg::NUM_SLOTS];

	instr_decoder u_decoder (
		.fetch(fetch), .fetch_valid(fetch_valid),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.sel1(sel1), .sel2(sel2), .slot_idx1(slot_idx1), .slot_idx2(slot_idx2),
		.alu_result(alu_result), .slot_data(slot_data), .stall(stall),
		.rs1(rs1), .rs2(rs2), .use1(use1), .use2(use2),
		.issue(issue), .issue_valid(issue_valid), .fetch_ready(fetch_ready)
	);

	hazard_unit u_hazard (
		.rs1(rs1), .rs2(rs2), .use1(use1), .use2(use2),
		.issue(issue_q), .issue_live(issue_live), .slots(slots),
		.sel1(sel1), .sel2(sel2), .slot_idx1(slot_idx1), .slot_idx2(slot_idx2),
		.stall(stall)
	);

	exec_unit u_exec (
		.clk(clk), .arst_n(arst_n), .issue(issue), .issue_valid(issue_valid),
		.issue_q(issue_q), .issue_live(issue_live), .alu_result(alu_result),
		.slot_in(slot_in), .mul_done(mul_done), .mul_data(mul_data)
	);

	// ------------------------------
	// Retire chain, slot 0 is youngest
	// ------------------------------
	for (genvar i = 0; i < core_pkg::NUM_SLOTS; i++) begin : g_slot
		retire_slot u_slot (
			.clk(clk), .arst_n(arst_n),
			.entry_in((i == 0) ? slot_in : slots[(i == 0) ? 0 : i - 1]),
			.mul_done(mul_done), .mul_data(mul_data),
			.entry(slots[i])
		);
		assign slot_data[i] = slots[i].data;
	end

	reg_file u_regs (
		.clk(clk), .arst_n(arst_n), .ra1(rs1), .ra2(rs2),
		.wr(slots[core_pkg::NUM_SLOTS-1]), .rd1(rs1_data), .rd2(rs2_data)
	);

	assign retire_valid = slots[core_pkg::NUM_SLOTS-1].valid && slots[core_pkg::NUM_SLOTS-1].we;
	assign retire.rd    = slots[core_pkg::NUM_SLOTS-1].rd;
	assign retire.data  = slots[core_pkg::NUM_SLOTS-1].data;

endmodule

`default_nettype wire

// ==== tb/issue_core_model.svh ====
// ------------------------------
// Random source and reference model
// ------------------------------
logic [31:0]     rng_state = 32'h3d13_aa7c;
core_pkg::xlen_t arch_regs [32];

function automatic logic [31:0] next_rand();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

// Kinds 0-9 OP, 10 MUL, 11-19 OP-IMM, 20 LUI, 21 AUIPC, 22 unknown opcode
function automatic logic [31:0] gen_inst(input int kind, input logic allow_x0);
	logic [31:0] r;
	logic [4:0]  rd;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [11:0] imm;
	r   = next_rand();
	rd  = allow_x0 ? {2'b0, r[2:0]} : 5'(r[7:0] % 7 + 1);         // Small set gives dependencies
	rs1 = {2'b0, r[10:8]};
	rs2 = {2'b0, r[13:11]};
	imm = 12'(next_rand());
	case (kind)
		0:  return {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
		1:  return {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};       // SUB
		2:  return {7'h00, rs2, rs1, 3'b001, rd, 7'b0110011};
		3:  return {7'h00, rs2, rs1, 3'b010, rd, 7'b0110011};
		4:  return {7'h00, rs2, rs1, 3'b011, rd, 7'b0110011};
		5:  return {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
		6:  return {7'h00, rs2, rs1, 3'b101, rd, 7'b0110011};
		7:  return {7'h20, rs2, rs1, 3'b101, rd, 7'b0110011};       // SRA
		8:  return {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
		9:  return {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
		10: return {7'h01, rs2, rs1, 3'b000, rd, 7'b0110011};       // MUL
		11: return {imm, rs1, 3'b000, rd, 7'b0010011};
		12: return {imm, rs1, 3'b010, rd, 7'b0010011};
		13: return {imm, rs1, 3'b011, rd, 7'b0010011};
		14: return {imm, rs1, 3'b100, rd, 7'b0010011};
		15: return {imm, rs1, 3'b110, rd, 7'b0010011};
		16: return {imm, rs1, 3'b111, rd, 7'b0010011};
		17: return {7'h00, imm[4:0], rs1, 3'b001, rd, 7'b0010011};
		18: return {7'h00, imm[4:0], rs1, 3'b101, rd, 7'b0010011};
		19: return {7'h20, imm[4:0], rs1, 3'b101, rd, 7'b0010011};
		20: return {next_rand() & 32'hffff_f000} | {20'b0, rd, 7'b0110111};
		21: return {next_rand() & 32'hffff_f000} | {20'b0, rd, 7'b0010111};
		default: return {r[31:12], rd, 7'b0000011};               // Load, decodes as bubble
	endcase
endfunction

// Executes one accepted instruction, returns 1 when it writes a nonzero rd
function automatic logic model_exec(input logic [31:0] inst, input core_pkg::xlen_t pc,
	output core_pkg::retire_t exp);
	core_pkg::xlen_t a;
	core_pkg::xlen_t b;
	core_pkg::xlen_t res;
	logic [6:0]      f7;
	logic [2:0]      f3;
	logic [4:0]      rd;
	logic            ok;
	a   = arch_regs[inst[19:15]];
	b   = arch_regs[inst[24:20]];
	f7  = inst[31:25];
	f3  = inst[14:12];
	rd  = inst[11:7];
	ok  = 1'b1;
	res = '0;
	if (inst[6:0] == 7'b0010011) begin
		b = {{20{inst[31]}}, inst[31:20]};                         // I immediate
		if (f3 == 3'b001 && f7 != 7'h00)
			ok = 1'b0;
		if (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20)
			ok = 1'b0;
		if (f3 != 3'b101)
			f7 = 7'h00;
	end else if (inst[6:0] == 7'b0110011) begin
		if (f7 == 7'h20)
			ok = (f3 == 3'b000) || (f3 == 3'b101);
		else if (f7 == 7'h01)
			ok = (f3 == 3'b000);
		else
			ok = (f7 == 7'h00);
	end
	case (inst[6:0])
		7'b0110111: res = {inst[31:12], 12'b0};
		7'b0010111: res = pc + {inst[31:12], 12'b0};
		7'b0110011, 7'b0010011: begin
			if (f7 == 7'h01)
				res = a * b;
			else case (f3)
				3'b000: res = (f7 == 7'h20) ? a - b : a + b;
				3'b001: res = a << b[4:0];
				3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				3'b011: res = (a < b) ? 32'd1 : 32'd0;
				3'b100: res = a ^ b;
				3'b101: res = (f7 == 7'h20) ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
				3'b110: res = a | b;
				default: res = a & b;
			endcase
		end
		default: ok = 1'b0;
	endcase
	exp.rd   = rd;
	exp.data = res;
	if (ok && rd != 5'd0) begin
		arch_regs[rd] = res;
		return 1'b1;
	end
	return 1'b0;
endfunction

// ==== tb/issue_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_core_tb;

	localparam int RUN_CYCLES = 20 + 8 * 22 + 100 + 2 * 20 + 100 + 2000 + 20;

	logic                  clk = 1'b0;
	logic                  arst_n;
	core_pkg::fetch_t      fetch;
	logic                  fetch_valid;
	logic                  fetch_ready;
	logic                  retire_valid;
	core_pkg::retire_t     retire;
	core_pkg::retire_t     exp_q [$];
	core_pkg::xlen_t       pc = 32'h0000_1000;
	int                    errors = 0;
	int                    checks = 0;
	int                    test_start = 0;

	`include "issue_core_model.svh"

	issue_core_top dut0 (
		.clk(clk), .arst_n(arst_n), .fetch(fetch), .fetch_valid(fetch_valid),
		.fetch_ready(fetch_ready), .retire_valid(retire_valid), .retire(retire)
	);

	always #20 clk = !clk;

	// ------------------------------
	// Checks
	// ------------------------------
	task automatic check_retire(input core_pkg::retire_t got, input core_pkg::retire_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: retire rd got 0x%h expected 0x%h, data got 0x%h expected 0x%h",
				got.rd, exp.rd, got.data, exp.data);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic end_test(input int num, input string name);
		$display("Test %0d %s: %0d errors", num, name, errors - test_start);
		test_start = errors;
	endtask

	// ------------------------------
	// Stimulus
	// ------------------------------
	task automatic idle_cycle();
		@(negedge clk);
		fetch_valid = 1'b0;
		fetch.inst  = next_rand();
	endtask

	// Holds the instruction until accepted, counts stall cycles
	task automatic issue_one(input logic [31:0] inst, output logic first_ready, output int stalls);
		core_pkg::retire_t exp;
		@(negedge clk);
		fetch_valid = 1'b1;
		fetch.inst  = inst;
		fetch.pc    = pc;
		stalls      = 0;
		#1;
		first_ready = fetch_ready;
		while (!fetch_ready) begin
			stalls++;
			@(negedge clk);
			#1;
		end
		if (model_exec(inst, pc, exp))
			exp_q.push_back(exp);
		pc = pc + 4;
	endtask

	function automatic logic [31:0] set_rs1(input logic [31:0] inst, input logic [4:0] r);
		return {inst[31:20], r, inst[14:0]};
	endfunction

	// Retire monitor, results are stable around the falling edge
	initial begin
		forever begin
			@(negedge clk);
			if (arst_n && retire_valid) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("Unexpected retire of rd %0d with no write outstanding", retire.rd);
				end else begin
					check_retire(retire, exp_q.pop_front());
				end
			end
		end
	end

	initial begin
		#(RUN_CYCLES * 40 * 4);
		$display("Watchdog expired before the tests finished");
		$display("Testbench failed");
		$finish;
	end

	initial begin
		logic        rdy;
		int          stalls;
		int          kind;
		logic [4:0]  prev_rd;
		logic [31:0] inst;
		arst_n      = 1'b0;
		fetch_valid = 1'b0;
		fetch       = '0;
		for (int i = 0; i < 32; i++)
			arch_regs[i] = '0;

		// Test 1, reset
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		#1;
		check_bit("fetch_ready", fetch_ready, 1'b1);
		check_bit("retire_valid", retire_valid, 1'b0);
		end_test(1, "reset");

		// Test 2, every ALU and immediate form
		for (int rep = 0; rep < 8; rep++)
			for (int k = 0; k < 22; k++)
				if (k != 10)
					issue_one(gen_inst(k, 1'b0), rdy, stalls);
		end_test(2, "alu and immediate ops");

		// Test 3, dependent chains without MUL
		prev_rd = 5'd1;
		for (int n = 0; n < 100; n++) begin
			kind = int'(next_rand() % 22);
			if (kind == 10)
				kind = 0;
			inst = set_rs1(gen_inst(kind, 1'b0), prev_rd);
			issue_one(inst, rdy, stalls);
			check_bit("fetch_ready", rdy, 1'b1);
			prev_rd = inst[11:7];
		end
		end_test(3, "dependent chains");

		// Test 4, MUL followed by a consumer
		for (int n = 0; n < 20; n++) begin
			inst = gen_inst(10, 1'b0);
			issue_one(inst, rdy, stalls);
			issue_one(set_rs1(gen_inst(0, 1'b0), inst[11:7]), rdy, stalls);
			check_bit("fetch_ready", rdy, 1'b0);
			if (stalls != 1) begin
				errors++;
				$display("MUL consumer stalled %0d cycles instead of one", stalls);
			end
		end
		end_test(4, "mul stall");

		// Test 5, bubbles
		for (int n = 0; n < 100; n++) begin
			if (n % 3 == 0)
				kind = 22;
			else
				kind = int'(next_rand() % 23);
			issue_one(gen_inst(kind, 1'b1), rdy, stalls);
		end
		end_test(5, "bubbles");

		// Test 6, mixed traffic with gaps
		for (int n = 0; n < 2000; n++) begin
			while (next_rand() % 4 == 0)
				idle_cycle();
			issue_one(gen_inst(int'(next_rand() % 23), 1'b1), rdy, stalls);
		end
		repeat (core_pkg::NUM_SLOTS + 4)
			idle_cycle();
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d expected writes never retired", exp_q.size());
		end
		end_test(6, "mixed traffic");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+tb
verilog/core_pkg.sv
verilog/instr_decoder.sv
verilog/hazard_unit.sv
verilog/exec_unit.sv
verilog/retire_slot.sv
verilog/reg_file.sv
verilog/issue_core_top.sv
tb/issue_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the issue core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module issue_core_tb \
	--Mdir obj_dir -o issue_core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/issue_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
